// File: include/eth_dma_macros.svh
`ifndef ETH_DMA_MACROS_SVH
`define ETH_DMA_MACROS_SVH

// Descriptor memory address, two words per descriptor
`define ETH_DMA_BD_ADDR_W 8

// Transmit frame buffer word address
`define ETH_DMA_BUFFER_W 11

// System memory side
`define ETH_DMA_AXI_ADDR_W 32
`define ETH_DMA_AXI_LEN_W 8
`define ETH_DMA_WORD_W 32

// Longest read burst in beats
`define ETH_DMA_MAX_BURST 16

// Control word bit positions
`define ETH_DMA_BD_READY 15
`define ETH_DMA_BD_IRQ 14
`define ETH_DMA_BD_WRAP 13
`define ETH_DMA_BD_CRC 11

// Byte count field of the control word
`define ETH_DMA_BD_LEN_LSB 16
`define ETH_DMA_BD_LEN_MSB 26

`endif

// File: source/eth_bd_pkg.sv
`include "eth_dma_macros.svh"

package eth_bd_pkg;

   // One word of a descriptor, control or pointer
   typedef logic [`ETH_DMA_WORD_W-1:0] bd_word_t;

   // Ring position, each descriptor takes a pair of words
   typedef logic [`ETH_DMA_BD_ADDR_W-2:0] bd_index_t;

   // Word address into descriptor memory
   typedef logic [`ETH_DMA_BD_ADDR_W-1:0] bd_addr_t;

   // Frame length in bytes as stored in the control word
   typedef logic [`ETH_DMA_BD_LEN_MSB-`ETH_DMA_BD_LEN_LSB:0] frame_bytes_t;

   // Descriptor polling and write-back FSM
   typedef enum logic [2:0] {
      fetch_idle,
      fetch_rd_ctrl,
      fetch_chk_ready,
      fetch_rd_ptr,
      fetch_offer,
      fetch_write_back
   } fetch_state_e;

endpackage

// File: source/eth_axi_pkg.sv
`include "eth_dma_macros.svh"

package eth_axi_pkg;

   typedef logic [`ETH_DMA_AXI_ADDR_W-1:0] axi_addr_t;
   // Beats in a burst minus one
   typedef logic [`ETH_DMA_AXI_LEN_W-1:0] axi_len_t;
   typedef logic [`ETH_DMA_WORD_W-1:0] axi_data_t;

   // Word address into the MAC transmit buffer
   typedef logic [`ETH_DMA_BUFFER_W-1:0] fb_addr_t;

   // Frame read FSM
   typedef enum logic [2:0] {
      burst_idle,
      burst_wait_buf,
      burst_addr,
      burst_data,
      burst_finish
   } burst_state_e;

endpackage

// File: source/eth_tx_stage_if.sv
`timescale 1ns/1ps

// Descriptor from the fetch stage to the burst reader
interface tx_desc_if;
   logic                    req;
   logic                    ack;
   eth_bd_pkg::bd_index_t   index;
   eth_axi_pkg::axi_addr_t  ptr;
   eth_bd_pkg::bd_word_t    ctrl;

   modport fetch_mp (output req, output index, output ptr, output ctrl, input ack);
   modport reader_mp (input req, input index, input ptr, input ctrl, output ack);
endinterface

// Frame fully copied into the transmit buffer
interface tx_frame_if;
   logic                    req;
   logic                    ack;
   eth_bd_pkg::bd_index_t   index;
   eth_bd_pkg::bd_word_t    ctrl;

   modport reader_mp (output req, output index, output ctrl, input ack);
   modport status_mp (input req, input index, input ctrl, output ack);
endinterface

// Control word to write back into the ring
interface tx_wb_if;
   logic                    req;
   logic                    ack;
   eth_bd_pkg::bd_index_t   index;
   eth_bd_pkg::bd_word_t    ctrl;

   modport status_mp (output req, output index, output ctrl, input ack);
   modport fetch_mp (input req, input index, input ctrl, output ack);
endinterface

// File: source/tx_bd_fetch.sv
`timescale 1ns/1ps

`include "eth_dma_macros.svh"

module tx_bd_fetch (
   input  logic                  clk_i,
   input  logic                  arst_i,
   input  logic                  tx_en_i,
   input  eth_bd_pkg::bd_addr_t  tx_bd_num_i,
   output eth_bd_pkg::bd_addr_t  bd_addr_o,
   output logic                  bd_wen_o,
   output eth_bd_pkg::bd_word_t  bd_o,
   input  eth_bd_pkg::bd_word_t  bd_i,
   tx_desc_if.fetch_mp           desc,
   tx_wb_if.fetch_mp             wb
);

   localparam int RING_SIZE = 2 ** $bits(eth_bd_pkg::bd_index_t);

   eth_bd_pkg::fetch_state_e state_q;
   eth_bd_pkg::bd_index_t    idx_q;
   eth_bd_pkg::bd_addr_t     idx_inc;
   eth_bd_pkg::bd_word_t     ctrl_q;
   eth_axi_pkg::axi_addr_t   ptr_q;
   logic                     desc_req_q;
   logic                     offer_q;
   logic                     wb_ack_q;
   logic                     wb_pend;
   logic [RING_SIZE-1:0]     busy_q;

   // Write-back waiting for the memory port
   assign wb_pend = wb.req && !wb_ack_q;
   assign idx_inc = {1'b0, idx_q} + 1'b1;

   always_ff @(posedge clk_i) begin
      if (arst_i) begin
         state_q    <= eth_bd_pkg::fetch_idle;
         idx_q      <= '0;
         desc_req_q <= 1'b0;
         offer_q    <= 1'b0;
         wb_ack_q   <= 1'b0;
         busy_q     <= '0;
      end else begin
         if (wb_ack_q && !wb.req) begin
            wb_ack_q <= 1'b0;
         end
         case (state_q)
            eth_bd_pkg::fetch_idle: begin
               if (wb_pend) begin
                  state_q <= eth_bd_pkg::fetch_write_back;
               end else if (tx_en_i && !busy_q[idx_q]) begin
                  state_q <= eth_bd_pkg::fetch_rd_ctrl;
               end
            end
            eth_bd_pkg::fetch_rd_ctrl: state_q <= eth_bd_pkg::fetch_chk_ready;
            eth_bd_pkg::fetch_chk_ready: begin
               // Not ready yet, poll again through idle
               state_q <= ctrl_q[`ETH_DMA_BD_READY] ? eth_bd_pkg::fetch_rd_ptr
                                                    : eth_bd_pkg::fetch_idle;
            end
            eth_bd_pkg::fetch_rd_ptr: begin
               desc_req_q <= 1'b1;
               offer_q    <= 1'b1;
               state_q    <= eth_bd_pkg::fetch_offer;
            end
            eth_bd_pkg::fetch_offer: begin
               if (wb_pend) begin
                  state_q <= eth_bd_pkg::fetch_write_back;
               end else if (desc_req_q && desc.ack) begin
                  desc_req_q    <= 1'b0;
                  busy_q[idx_q] <= 1'b1;
               end else if (!desc_req_q && !desc.ack) begin
                  offer_q <= 1'b0;
                  state_q <= eth_bd_pkg::fetch_idle;
                  if (ctrl_q[`ETH_DMA_BD_WRAP] || idx_inc >= tx_bd_num_i) begin
                     idx_q <= '0;
                  end else begin
                     idx_q <= idx_inc[$bits(idx_q)-1:0];
                  end
               end
            end
            eth_bd_pkg::fetch_write_back: begin
               wb_ack_q         <= 1'b1;
               busy_q[wb.index] <= 1'b0;
               state_q <= offer_q ? eth_bd_pkg::fetch_offer : eth_bd_pkg::fetch_idle;
            end
            default: state_q <= eth_bd_pkg::fetch_idle;
         endcase
      end
   end

   // Memory data arrives one cycle after its address
   always_ff @(posedge clk_i) begin
      if (state_q == eth_bd_pkg::fetch_rd_ctrl) begin
         ctrl_q <= bd_i;
      end
      if (state_q == eth_bd_pkg::fetch_rd_ptr) begin
         ptr_q <= bd_i;
      end
   end

   always_comb begin
      bd_addr_o = {idx_q, 1'b0};
      bd_wen_o  = 1'b0;
      case (state_q)
         eth_bd_pkg::fetch_chk_ready: bd_addr_o = {idx_q, 1'b1};
         eth_bd_pkg::fetch_write_back: begin
            bd_addr_o = {wb.index, 1'b0};
            bd_wen_o  = 1'b1;
         end
         default: ;
      endcase
   end

   assign bd_o       = wb.ctrl;
   assign wb.ack     = wb_ack_q;
   assign desc.req   = desc_req_q;
   assign desc.index = idx_q;
   assign desc.ptr   = ptr_q;
   assign desc.ctrl  = ctrl_q;

endmodule

// File: source/tx_burst_reader.sv
`timescale 1ns/1ps

`include "eth_dma_macros.svh"

module tx_burst_reader (
   input  logic                    clk_i,
   input  logic                    arst_i,
   tx_desc_if.reader_mp            desc,
   tx_frame_if.reader_mp           frame,
   input  logic                    tx_ready_i,
   output eth_axi_pkg::axi_addr_t  axi_araddr_o,
   output eth_axi_pkg::axi_len_t   axi_arlen_o,
   output logic                    axi_arvalid_o,
   input  logic                    axi_arready_i,
   input  eth_axi_pkg::axi_data_t  axi_rdata_i,
   input  logic                    axi_rvalid_i,
   input  logic                    axi_rlast_i,
   output logic                    axi_rready_o,
   output logic                    fb_wen_o,
   output eth_axi_pkg::fb_addr_t   fb_addr_o,
   output eth_axi_pkg::axi_data_t  fb_wdata_o
);

   eth_axi_pkg::burst_state_e state_q;
   eth_bd_pkg::bd_index_t     idx_q;
   eth_bd_pkg::bd_word_t      ctrl_q;
   eth_axi_pkg::axi_addr_t    ptr_q;
   eth_axi_pkg::fb_addr_t     words_q;
   eth_axi_pkg::fb_addr_t     done_q;
   eth_axi_pkg::fb_addr_t     remaining;
   eth_axi_pkg::fb_addr_t     burst_beats;
   eth_bd_pkg::frame_bytes_t  desc_bytes;
   logic                      desc_ack_q;
   logic                      frame_req_q;
   logic                      accept;
   logic                      beat;

   assign accept     = (state_q == eth_axi_pkg::burst_idle) && desc.req && !desc_ack_q;
   assign beat       = (state_q == eth_axi_pkg::burst_data) && axi_rvalid_i;
   assign desc_bytes = desc.ctrl[`ETH_DMA_BD_LEN_MSB:`ETH_DMA_BD_LEN_LSB];

   always_ff @(posedge clk_i) begin
      if (arst_i) begin
         state_q     <= eth_axi_pkg::burst_idle;
         desc_ack_q  <= 1'b0;
         frame_req_q <= 1'b0;
         done_q      <= '0;
      end else begin
         if (desc_ack_q && !desc.req) begin
            desc_ack_q <= 1'b0;
         end
         case (state_q)
            eth_axi_pkg::burst_idle: begin
               if (accept) begin
                  desc_ack_q <= 1'b1;
                  done_q     <= '0;
                  state_q    <= eth_axi_pkg::burst_wait_buf;
               end
            end
            eth_axi_pkg::burst_wait_buf: begin
               // MAC buffer must be free before the first burst
               if (tx_ready_i) begin
                  if (words_q == '0) begin
                     frame_req_q <= 1'b1;
                     state_q     <= eth_axi_pkg::burst_finish;
                  end else begin
                     state_q <= eth_axi_pkg::burst_addr;
                  end
               end
            end
            eth_axi_pkg::burst_addr: begin
               if (axi_arready_i) begin
                  state_q <= eth_axi_pkg::burst_data;
               end
            end
            eth_axi_pkg::burst_data: begin
               if (beat) begin
                  done_q <= done_q + 1'b1;
                  if (done_q + 1'b1 == words_q) begin
                     frame_req_q <= 1'b1;
                     state_q     <= eth_axi_pkg::burst_finish;
                  end else if (axi_rlast_i) begin
                     state_q <= eth_axi_pkg::burst_addr;
                  end
               end
            end
            eth_axi_pkg::burst_finish: begin
               if (frame_req_q && frame.ack) begin
                  frame_req_q <= 1'b0;
               end else if (!frame_req_q && !frame.ack) begin
                  state_q <= eth_axi_pkg::burst_idle;
               end
            end
            default: state_q <= eth_axi_pkg::burst_idle;
         endcase
      end
   end

   // Frame length rounded up to whole words
   always_ff @(posedge clk_i) begin
      if (accept) begin
         idx_q   <= desc.index;
         ctrl_q  <= desc.ctrl;
         ptr_q   <= desc.ptr;
         words_q <= eth_axi_pkg::fb_addr_t'(({1'b0, desc_bytes} + 12'd3) >> 2);
      end
   end

   assign remaining   = words_q - done_q;
   assign burst_beats = (remaining > eth_axi_pkg::fb_addr_t'(`ETH_DMA_MAX_BURST))
                        ? eth_axi_pkg::fb_addr_t'(`ETH_DMA_MAX_BURST) : remaining;

   assign axi_araddr_o  = ptr_q + eth_axi_pkg::axi_addr_t'({done_q, 2'b00});
   assign axi_arlen_o   = eth_axi_pkg::axi_len_t'(burst_beats - 1'b1);
   assign axi_arvalid_o = (state_q == eth_axi_pkg::burst_addr);
   assign axi_rready_o  = beat;

   // One buffer word per accepted beat
   assign fb_wen_o   = beat;
   assign fb_addr_o  = done_q;
   assign fb_wdata_o = axi_rdata_i;

   assign desc.ack    = desc_ack_q;
   assign frame.req   = frame_req_q;
   assign frame.index = idx_q;
   assign frame.ctrl  = ctrl_q;

endmodule

// File: source/tx_status_writer.sv
`timescale 1ns/1ps

`include "eth_dma_macros.svh"

module tx_status_writer (
   input  logic                      clk_i,
   input  logic                      arst_i,
   tx_frame_if.status_mp             frame,
   tx_wb_if.status_mp                wb,
   output logic                      send_o,
   output logic                      crc_en_o,
   output eth_bd_pkg::frame_bytes_t  tx_nbytes_o,
   output logic                      tx_irq_o
);

   eth_bd_pkg::bd_index_t idx_q;
   eth_bd_pkg::bd_word_t  wb_ctrl_q;
   logic                  frame_ack_q;
   logic                  wb_req_q;
   logic                  busy_q;
   logic                  accept;

   // Busy from accept until the write-back handshake is over
   assign accept = frame.req && !frame_ack_q && !busy_q;

   always_ff @(posedge clk_i) begin
      if (arst_i) begin
         frame_ack_q <= 1'b0;
         wb_req_q    <= 1'b0;
         busy_q      <= 1'b0;
         send_o      <= 1'b0;
         tx_irq_o    <= 1'b0;
      end else begin
         send_o   <= accept;
         tx_irq_o <= accept && frame.ctrl[`ETH_DMA_BD_IRQ];

         if (accept) begin
            frame_ack_q <= 1'b1;
         end else if (frame_ack_q && !frame.req) begin
            frame_ack_q <= 1'b0;
         end

         if (accept) begin
            wb_req_q <= 1'b1;
         end else if (wb_req_q && wb.ack) begin
            wb_req_q <= 1'b0;
         end

         if (accept) begin
            busy_q <= 1'b1;
         end else if (busy_q && !wb_req_q && !wb.ack) begin
            busy_q <= 1'b0;
         end
      end
   end

   // MAC settings stay put until the next frame
   always_ff @(posedge clk_i) begin
      if (accept) begin
         idx_q       <= frame.index;
         crc_en_o    <= frame.ctrl[`ETH_DMA_BD_CRC];
         tx_nbytes_o <= frame.ctrl[`ETH_DMA_BD_LEN_MSB:`ETH_DMA_BD_LEN_LSB];
         wb_ctrl_q   <= frame.ctrl & ~(eth_bd_pkg::bd_word_t'(1) << `ETH_DMA_BD_READY);
      end
   end

   assign frame.ack = frame_ack_q;
   assign wb.req    = wb_req_q;
   assign wb.index  = idx_q;
   assign wb.ctrl   = wb_ctrl_q;

endmodule

// File: source/eth_tx_dma.sv
`timescale 1ns/1ps

`include "eth_dma_macros.svh"

module eth_tx_dma (
   input  logic                                          clk_i,
   input  logic                                          arst_i,
   input  logic                                          tx_en_i,
   input  logic [`ETH_DMA_BD_ADDR_W-1:0]                 tx_bd_num_i,
   // Descriptor memory
   output logic [`ETH_DMA_BD_ADDR_W-1:0]                 bd_addr_o,
   output logic                                          bd_wen_o,
   output logic [`ETH_DMA_WORD_W-1:0]                    bd_o,
   input  logic [`ETH_DMA_WORD_W-1:0]                    bd_i,
   // AXI read channel
   output logic [`ETH_DMA_AXI_ADDR_W-1:0]                axi_araddr_o,
   output logic [`ETH_DMA_AXI_LEN_W-1:0]                 axi_arlen_o,
   output logic                                          axi_arvalid_o,
   input  logic                                          axi_arready_i,
   input  logic [`ETH_DMA_WORD_W-1:0]                    axi_rdata_i,
   input  logic                                          axi_rvalid_i,
   input  logic                                          axi_rlast_i,
   output logic                                          axi_rready_o,
   // MAC transmit buffer and control
   output logic                                          fb_wen_o,
   output logic [`ETH_DMA_BUFFER_W-1:0]                  fb_addr_o,
   output logic [`ETH_DMA_WORD_W-1:0]                    fb_wdata_o,
   input  logic                                          tx_ready_i,
   output logic                                          send_o,
   output logic                                          crc_en_o,
   output logic [`ETH_DMA_BD_LEN_MSB-`ETH_DMA_BD_LEN_LSB:0] tx_nbytes_o,
   output logic                                          tx_irq_o
);

   tx_desc_if  desc_if ();
   tx_frame_if frame_if ();
   tx_wb_if    wb_if ();

   tx_bd_fetch u_fetch (
      .clk_i       (clk_i),
      .arst_i      (arst_i),
      .tx_en_i     (tx_en_i),
      .tx_bd_num_i (tx_bd_num_i),
      .bd_addr_o   (bd_addr_o),
      .bd_wen_o    (bd_wen_o),
      .bd_o        (bd_o),
      .bd_i        (bd_i),
      .desc        (desc_if.fetch_mp),
      .wb          (wb_if.fetch_mp)
   );

   tx_burst_reader u_reader (
      .clk_i         (clk_i),
      .arst_i        (arst_i),
      .desc          (desc_if.reader_mp),
      .frame         (frame_if.reader_mp),
      .tx_ready_i    (tx_ready_i),
      .axi_araddr_o  (axi_araddr_o),
      .axi_arlen_o   (axi_arlen_o),
      .axi_arvalid_o (axi_arvalid_o),
      .axi_arready_i (axi_arready_i),
      .axi_rdata_i   (axi_rdata_i),
      .axi_rvalid_i  (axi_rvalid_i),
      .axi_rlast_i   (axi_rlast_i),
      .axi_rready_o  (axi_rready_o),
      .fb_wen_o      (fb_wen_o),
      .fb_addr_o     (fb_addr_o),
      .fb_wdata_o    (fb_wdata_o)
   );

   tx_status_writer u_status (
      .clk_i       (clk_i),
      .arst_i      (arst_i),
      .frame       (frame_if.status_mp),
      .wb          (wb_if.status_mp),
      .send_o      (send_o),
      .crc_en_o    (crc_en_o),
      .tx_nbytes_o (tx_nbytes_o),
      .tx_irq_o    (tx_irq_o)
   );

endmodule

// File: verification/eth_tx_dma_checker.sv
`timescale 1ns/1ps

`include "eth_dma_macros.svh"

module eth_tx_dma_checker (
   input logic                            clk_i,
   input logic                            arst_i,
   input logic                            arvalid_i,
   input logic                            arready_i,
   input logic [`ETH_DMA_AXI_ADDR_W-1:0]  araddr_i,
   input logic [`ETH_DMA_AXI_LEN_W-1:0]   arlen_i,
   input logic                            send_i,
   input logic                            desc_req_i,
   input logic                            desc_ack_i,
   input logic                            frame_req_i,
   input logic                            frame_ack_i,
   input logic                            wb_req_i,
   input logic                            wb_ack_i
);

   int fail_count = 0;

   // Address channel is frozen while the slave stalls
   ar_hold: assert property (@(posedge clk_i) disable iff (arst_i)
      arvalid_i && !arready_i |=> arvalid_i && $stable(araddr_i) && $stable(arlen_i))
      else begin
         fail_count++;
         $error("arvalid dropped or the address changed before arready");
      end

   ar_len_max: assert property (@(posedge clk_i) disable iff (arst_i)
      arvalid_i |-> arlen_i <= `ETH_DMA_AXI_LEN_W'(`ETH_DMA_MAX_BURST - 1))
      else begin
         fail_count++;
         $error("arlen exceeds the burst limit");
      end

   // Four-phase handshakes, req may only fall after ack
   desc_req_hold: assert property (@(posedge clk_i) disable iff (arst_i)
      desc_req_i && !desc_ack_i |=> desc_req_i)
      else begin
         fail_count++;
         $error("descriptor req fell before ack");
      end

   frame_req_hold: assert property (@(posedge clk_i) disable iff (arst_i)
      frame_req_i && !frame_ack_i |=> frame_req_i)
      else begin
         fail_count++;
         $error("frame req fell before ack");
      end

   wb_req_hold: assert property (@(posedge clk_i) disable iff (arst_i)
      wb_req_i && !wb_ack_i |=> wb_req_i)
      else begin
         fail_count++;
         $error("write-back req fell before ack");
      end

   send_pulse: assert property (@(posedge clk_i) disable iff (arst_i)
      send_i |=> !send_i)
      else begin
         fail_count++;
         $error("send_o stayed high for more than one cycle");
      end

endmodule

bind eth_tx_dma eth_tx_dma_checker u_checker (
   .clk_i       (clk_i),
   .arst_i      (arst_i),
   .arvalid_i   (axi_arvalid_o),
   .arready_i   (axi_arready_i),
   .araddr_i    (axi_araddr_o),
   .arlen_i     (axi_arlen_o),
   .send_i      (send_o),
   .desc_req_i  (desc_if.req),
   .desc_ack_i  (desc_if.ack),
   .frame_req_i (frame_if.req),
   .frame_ack_i (frame_if.ack),
   .wb_req_i    (wb_if.req),
   .wb_ack_i    (wb_if.ack)
);

// File: verification/tb_eth_tx_dma.sv
`timescale 1ns/1ps

`include "eth_dma_macros.svh"

module tb_eth_tx_dma;

   localparam int unsigned DRAIN_LIMIT  = 3000;
   localparam int unsigned QUIET_CYCLES = 40;

   logic                                             clk;
   logic                                             arst;
   logic                                             tx_en;
   logic [`ETH_DMA_BD_ADDR_W-1:0]                    tx_bd_num;
   logic [`ETH_DMA_BD_ADDR_W-1:0]                    bd_addr;
   logic                                             bd_wen;
   logic [`ETH_DMA_WORD_W-1:0]                       bd_wdata;
   logic [`ETH_DMA_WORD_W-1:0]                       bd_rdata;
   logic [`ETH_DMA_AXI_ADDR_W-1:0]                   ar_addr;
   logic [`ETH_DMA_AXI_LEN_W-1:0]                    ar_len;
   logic                                             ar_valid;
   logic                                             ar_ready;
   logic [`ETH_DMA_WORD_W-1:0]                       r_data;
   logic                                             r_valid;
   logic                                             r_last;
   logic                                             r_ready;
   logic                                             fb_wen;
   logic [`ETH_DMA_BUFFER_W-1:0]                     fb_addr;
   logic [`ETH_DMA_WORD_W-1:0]                       fb_wdata;
   logic                                             tx_ready;
   logic                                             send;
   logic                                             crc_en;
   logic [`ETH_DMA_BD_LEN_MSB-`ETH_DMA_BD_LEN_LSB:0] tx_nbytes;
   logic                                             tx_irq;

   // Memory models and scoreboard
   logic [31:0]                   bd_mem [0:(1 << `ETH_DMA_BD_ADDR_W)-1];
   logic [31:0]                   fb_mem [0:(1 << `ETH_DMA_BUFFER_W)-1];
   logic [`ETH_DMA_BD_ADDR_W-1:0] bd_addr_q;
   logic [31:0]                   rnd;
   logic [31:0]                   br_addr_q [$];
   int unsigned                   br_len_q [$];
   logic [31:0]                   exp_ctrl_q [$];
   logic [31:0]                   exp_ptr_q [$];
   logic [31:0]                   wb_ctrl_q [$];
   int unsigned                   wb_slot_q [$];
   int unsigned                   r_beat;
   int unsigned                   fb_writes;
   string                         test_name;
   int unsigned                   tests;
   int unsigned                   checks;
   int unsigned                   errors;
   int unsigned                   test_checks;
   int unsigned                   test_errors;

   eth_tx_dma u_dut (
      .clk_i         (clk),
      .arst_i        (arst),
      .tx_en_i       (tx_en),
      .tx_bd_num_i   (tx_bd_num),
      .bd_addr_o     (bd_addr),
      .bd_wen_o      (bd_wen),
      .bd_o          (bd_wdata),
      .bd_i          (bd_rdata),
      .axi_araddr_o  (ar_addr),
      .axi_arlen_o   (ar_len),
      .axi_arvalid_o (ar_valid),
      .axi_arready_i (ar_ready),
      .axi_rdata_i   (r_data),
      .axi_rvalid_i  (r_valid),
      .axi_rlast_i   (r_last),
      .axi_rready_o  (r_ready),
      .fb_wen_o      (fb_wen),
      .fb_addr_o     (fb_addr),
      .fb_wdata_o    (fb_wdata),
      .tx_ready_i    (tx_ready),
      .send_o        (send),
      .crc_en_o      (crc_en),
      .tx_nbytes_o   (tx_nbytes),
      .tx_irq_o      (tx_irq)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   // System memory contents, every bit mixes two address bits
   function automatic logic [31:0] axi_word(input logic [31:0] a);
      return a ^ {a[15:0], a[31:16]} ^ 32'h3c5a_0f96;
   endfunction

   function automatic int unsigned words_for_bytes(input int unsigned b);
      return (b + 3) / 4;
   endfunction

   task automatic report_failure(input string what);
      $display("ERROR: %s in test %s", what, test_name);
      errors++;
      test_errors++;
   endtask

   task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
      checks++;
      test_checks++;
      assert (exp === act) else begin
         $display("MISMATCH %s/%s expected %h actual %h", test_name, name, exp, act);
         errors++;
         test_errors++;
      end
   endtask

   task automatic write_desc(input int unsigned slot, input int unsigned bytes, input logic irq,
                             input logic wrap, input logic crc, input logic ready,
                             input logic [31:0] ptr);
      logic [31:0] c;
      c = '0;
      c[`ETH_DMA_BD_LEN_MSB:`ETH_DMA_BD_LEN_LSB] = bytes[`ETH_DMA_BD_LEN_MSB-`ETH_DMA_BD_LEN_LSB:0];
      c[`ETH_DMA_BD_READY] = ready;
      c[`ETH_DMA_BD_IRQ]   = irq;
      c[`ETH_DMA_BD_WRAP]  = wrap;
      c[`ETH_DMA_BD_CRC]   = crc;
      bd_mem[2 * slot + 1] = ptr;
      bd_mem[2 * slot]     = c;
      // Armed descriptors are expected in the order they are armed
      if (ready) begin
         exp_ctrl_q.push_back(c);
         exp_ptr_q.push_back(ptr);
         wb_ctrl_q.push_back(c);
         wb_slot_q.push_back(slot);
      end
   endtask

   task automatic drive_axi();
      rnd = lcg_next(rnd);
      ar_ready = (rnd[31:30] != 2'b00);
      rnd = lcg_next(rnd);
      if (br_addr_q.size() != 0) begin
         r_valid = (rnd[31:30] != 2'b00);
         r_data  = axi_word(br_addr_q[0] + 32'(4 * r_beat));
         r_last  = (r_beat == br_len_q[0]);
      end else begin
         r_valid = 1'b0;
         r_last  = 1'b0;
      end
   endtask

   task automatic sample_axi();
      if (r_valid && r_ready) begin
         if (r_beat == br_len_q[0]) begin
            void'(br_addr_q.pop_front());
            void'(br_len_q.pop_front());
            r_beat = 0;
         end else begin
            r_beat++;
         end
      end
      if (ar_valid && ar_ready) begin
         br_addr_q.push_back(ar_addr);
         br_len_q.push_back(32'(ar_len));
      end
   endtask

   task automatic sample_outputs();
      logic [31:0] c;
      logic [31:0] p;
      logic [31:0] wb_exp;
      int unsigned n;
      int unsigned slot;
      if (fb_wen) begin
         fb_mem[fb_addr] = fb_wdata;
         fb_writes++;
      end
      if (send) begin
         assert (exp_ctrl_q.size() != 0) else report_failure("send_o pulsed with nothing armed");
         if (exp_ctrl_q.size() != 0) begin
            c = exp_ctrl_q.pop_front();
            p = exp_ptr_q.pop_front();
            n = words_for_bytes(32'(c[`ETH_DMA_BD_LEN_MSB:`ETH_DMA_BD_LEN_LSB]));
            check_value("tx_nbytes", 32'(c[`ETH_DMA_BD_LEN_MSB:`ETH_DMA_BD_LEN_LSB]),
                        32'(tx_nbytes));
            check_value("crc_en", 32'(c[`ETH_DMA_BD_CRC]), 32'(crc_en));
            check_value("tx_irq", 32'(c[`ETH_DMA_BD_IRQ]), 32'(tx_irq));
            check_value("frame_words", n, fb_writes);
            for (int i = 0; i < n; i++) begin
               check_value($sformatf("fb_word[%0d]", i), axi_word(p + 32'(4 * i)), fb_mem[i]);
            end
         end
         fb_writes = 0;
      end else begin
         assert (!tx_irq) else report_failure("tx_irq_o pulsed without a frame being sent");
      end
      if (bd_wen) begin
         bd_mem[bd_addr] = bd_wdata;
         assert (wb_slot_q.size() != 0) else report_failure("write-back with nothing in flight");
         if (wb_slot_q.size() != 0) begin
            slot = wb_slot_q.pop_front();
            wb_exp = wb_ctrl_q.pop_front();
            wb_exp[`ETH_DMA_BD_READY] = 1'b0;
            check_value("wb_addr", 32'(2 * slot), 32'(bd_addr));
            check_value("wb_ctrl", wb_exp, bd_wdata);
         end
      end
   endtask

   // Drive on the falling edge, sample once everything has settled
   initial begin
      forever begin
         @(negedge clk);
         drive_axi();
         bd_rdata = bd_mem[bd_addr_q];
         #1;
         sample_axi();
         sample_outputs();
         bd_addr_q = bd_addr;
      end
   end

   task automatic wait_drained(input int unsigned limit);
      int unsigned n;
      n = 0;
      while ((exp_ctrl_q.size() != 0 || wb_slot_q.size() != 0) && n < limit) begin
         @(negedge clk);
         n++;
      end
      assert (exp_ctrl_q.size() == 0 && wb_slot_q.size() == 0) else
         report_failure($sformatf("timeout, frames still outstanding after %0d cycles", limit));
   endtask

   task automatic start_test(input string name);
      test_name   = name;
      test_checks = 0;
      test_errors = 0;
   endtask

   task automatic end_test();
      tests++;
      $display("test %-12s %0d checks, %0d errors", test_name, test_checks, test_errors);
   endtask

   initial begin
      arst      = 1'b1;
      tx_en     = 1'b0;
      tx_bd_num = 8'd4;
      bd_rdata  = '0;
      ar_ready  = 1'b0;
      r_data    = '0;
      r_valid   = 1'b0;
      r_last    = 1'b0;
      tx_ready  = 1'b1;
      bd_addr_q = '0;
      rnd       = 32'h68f2_bd04;
      r_beat    = 0;
      fb_writes = 0;
      tests     = 0;
      checks    = 0;
      errors    = 0;
      test_name = "reset";
      for (int k = 0; k < (1 << `ETH_DMA_BD_ADDR_W); k++) begin
         bd_mem[k] = '0;
      end
      repeat (2) @(posedge clk);
      @(negedge clk);
      arst = 1'b0;

      // Four descriptors, one of them crossing a burst boundary
      start_test("ring");
      check_value("reset_outputs", 32'd0, 32'({bd_wen, ar_valid, r_ready, fb_wen, send, tx_irq}));
      write_desc(0, 3, 1'b1, 1'b0, 1'b1, 1'b1, 32'h0001_0000);
      write_desc(1, 64, 1'b0, 1'b0, 1'b1, 1'b1, 32'h0001_0400);
      write_desc(2, 70, 1'b1, 1'b0, 1'b0, 1'b1, 32'h0001_0800);
      write_desc(3, 1, 1'b0, 1'b0, 1'b0, 1'b1, 32'h0001_0c00);
      tx_en = 1'b1;
      wait_drained(DRAIN_LIMIT);
      end_test();

      // Slot 0 sits without its ready bit, then gets armed
      start_test("ready_gate");
      write_desc(0, 20, 1'b1, 1'b0, 1'b0, 1'b0, 32'h0002_0000);
      repeat (QUIET_CYCLES) @(negedge clk);
      check_value("idle_fb_writes", 32'd0, fb_writes);
      write_desc(0, 20, 1'b1, 1'b0, 1'b0, 1'b1, 32'h0002_0000);
      wait_drained(DRAIN_LIMIT);
      end_test();

      // Wrap on slot 1 sends the refilled slot 0 next, MAC busy at first
      start_test("wrap_stall");
      tx_ready = 1'b0;
      write_desc(1, 40, 1'b1, 1'b1, 1'b0, 1'b1, 32'h0003_0100);
      write_desc(0, 9, 1'b0, 1'b0, 1'b1, 1'b1, 32'h0003_0800);
      repeat (QUIET_CYCLES) @(negedge clk);
      check_value("stall_fb_writes", 32'd0, fb_writes);
      tx_ready = 1'b1;
      wait_drained(DRAIN_LIMIT);
      end_test();

      repeat (4) @(negedge clk);
      errors = errors + u_dut.u_checker.fail_count;
      $display("total: %0d tests, %0d checks, %0d errors", tests, checks, errors);
      if (errors == 0) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   end

endmodule

// File: sources.f
+incdir+include
source/eth_bd_pkg.sv
source/eth_axi_pkg.sv
source/eth_tx_stage_if.sv
source/tx_bd_fetch.sv
source/tx_burst_reader.sv
source/tx_status_writer.sv
source/eth_tx_dma.sv
verification/eth_tx_dma_checker.sv
verification/tb_eth_tx_dma.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_eth_tx_dma
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing --assert
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_TEXT ?= Simulation PASSED

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

sim: build
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
